/* hdl/dwnld_ctrl.sv */
// ROM download control
// samples loader strobes, routes each byte to the PROM or to SDRAM, builds
// the 16-bit program request and holds prog_we until the memory answers
`timescale 1ns/1ps
`include "dwnld_settings.svh"

module dwnld_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      downloading,
    input  logic                      ioctl_wr,
    input  dwnld_pkg::ioctl_beat_t    beat,
    input  dwnld_pkg::region_t        region,
    input  logic                      sdram_ack,
    output dwnld_pkg::prog_req_t      req,
    output logic                      prog_we,
    output logic [`DWNLD_PROM_AW-1:0] prom_addr,
    output logic [7:0]                prom_data,
    output logic                      prom_we
);

    localparam logic SWAB = 1'(`DWNLD_SWAB);

    // a strobe that actually carries image data
    logic accept;
    // lane that the current byte lands on, 1 is data[15:8]
    logic upper_lane;

    assign accept     = ioctl_wr && downloading && !region.header;
    assign upper_lane = region.rel_addr[0] ^ SWAB;

    ////////////////////////////////////////////////////////////
    // payload registers

    // only loaded on an accepted beat, the enables tell when they are valid
    always_ff @(posedge clk) begin
        if (accept) begin
            if (region.prom) begin
                prom_addr <= region.prom_addr;
                prom_data <= beat.data;
            end else begin
                // two consecutive bytes share one 16-bit word
                req.addr <= region.rel_addr[22:1];
                req.data <= {2{beat.data}};
                req.mask <= upper_lane ? 2'b01 : 2'b10;
                req.ba   <= region.bank;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // write enables

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else if (accept) begin
            // a new beat always takes over from whatever was pending
            prog_we <= !region.prom;
            prom_we <= region.prom;
        end else begin
            // prog_we waits for the memory, prom_we only for the end
            // of the download
            if (!downloading || sdram_ack) begin
                prog_we <= 1'b0;
            end
            if (!downloading) begin
                prom_we <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // loader spacing

    // the loader has no stall, so a strobe may only show up once the
    // pending SDRAM write has been acknowledged (the ack cycle itself is fine)
    a_no_strobe_pending: assert property (
        @(posedge clk) disable iff (reset)
        (ioctl_wr && downloading) |-> (!prog_we || sdram_ack)
    ) else $error("ioctl strobe while an SDRAM write is still pending");

endmodule

/* hdl/dwnld_pkg.sv */
// ROM download types
// packed structs passed between the loader-facing datapath, the control
// logic and the SDRAM program store
`include "dwnld_settings.svh"

package dwnld_pkg;

    ////////////////////////////////////////////////////////////
    // loader side

    // one byte from the host loader as it appears on the ioctl bus
    typedef struct packed {
        logic [24:0] addr;
        logic [7:0]  data;
    } ioctl_beat_t;

    ////////////////////////////////////////////////////////////
    // decoded destination of a byte

    // header and prom are flags, the rest only matters for the flagged
    // destination (SDRAM when neither flag is set)
    typedef struct packed {
        logic                      header;
        logic                      prom;
        logic [1:0]                bank;
        // byte address relative to the start of the chosen bank
        logic [24:0]               rel_addr;
        // byte offset from the start of the PROM region
        logic [`DWNLD_PROM_AW-1:0] prom_addr;
    } region_t;

    ////////////////////////////////////////////////////////////
    // SDRAM programming request

    // the same byte sits on both lanes and the mask picks the one to write
    typedef struct packed {
        // 16-bit word address inside the bank
        logic [21:0] addr;
        logic [15:0] data;
        // active low, bit 1 guards data[15:8] and bit 0 guards data[7:0]
        logic [1:0]  mask;
        logic [1:0]  ba;
    } prog_req_t;

endpackage

/* hdl/dwnld_region_decode.sv */
// ROM download address decoder
// strips the header from the loader address, picks the SDRAM bank from the
// fixed bank starts and flags bytes that belong to the PROM region
// purely combinational
`timescale 1ns/1ps
`include "dwnld_settings.svh"

module dwnld_region_decode (
    input  dwnld_pkg::ioctl_beat_t beat,
    output dwnld_pkg::region_t     region
);

    // all layout constants widened to the loader address width
    localparam logic [24:0] HEADER_LEN = 25'(`DWNLD_HEADER_LEN);
    localparam logic [24:0] BA1_START  = 25'(`DWNLD_BA1_START);
    localparam logic [24:0] BA2_START  = 25'(`DWNLD_BA2_START);
    localparam logic [24:0] BA3_START  = 25'(`DWNLD_BA3_START);
    localparam logic [24:0] PROM_START = 25'(`DWNLD_PROM_START);

    // address counted from the first byte after the header
    logic [24:0] part_addr;
    // start of the chosen bank
    logic [24:0] bank_offset;
    logic [1:0]  bank;
    // distance from the PROM start, only meaningful inside the PROM region
    logic [24:0] prom_offset;

    ////////////////////////////////////////////////////////////
    // header strip

    // header bytes wrap around here but are flagged and never written
    assign part_addr = beat.addr - HEADER_LEN;

    ////////////////////////////////////////////////////////////
    // bank select

    // compare from the highest start down so the last matching bank wins
    always_comb begin
        if (part_addr >= BA3_START) begin
            bank        = 2'd3;
            bank_offset = BA3_START;
        end else if (part_addr >= BA2_START) begin
            bank        = 2'd2;
            bank_offset = BA2_START;
        end else if (part_addr >= BA1_START) begin
            bank        = 2'd1;
            bank_offset = BA1_START;
        end else begin
            bank        = 2'd0;
            bank_offset = '0;
        end
    end

    assign prom_offset = part_addr - PROM_START;

    ////////////////////////////////////////////////////////////
    // region output

    always_comb begin
        region.header    = beat.addr < HEADER_LEN;
        region.prom      = part_addr >= PROM_START;
        region.bank      = bank;
        region.rel_addr  = part_addr - bank_offset;
        // the PROM is small, only the low offset bits address it
        region.prom_addr = prom_offset[`DWNLD_PROM_AW-1:0];
    end

endmodule

/* hdl/dwnld_settings.svh */
// ROM download settings
// image layout, memory sizes and SDRAM acknowledge latency shared by the
// download datapath, the control logic and the behavioral stores
`ifndef DWNLD_SETTINGS_SVH
`define DWNLD_SETTINGS_SVH

////////////////////////////////////////////////////////////
// image layout, byte addresses in the loader address space

// bytes dropped at the start of the stream
`define DWNLD_HEADER_LEN 16
// bank starts and PROM start are counted after the header
`define DWNLD_BA1_START 'h80
`define DWNLD_BA2_START 'h100
`define DWNLD_BA3_START 'h180
`define DWNLD_PROM_START 'h200
// 1 places even bytes on the upper lane instead of the lower one
`define DWNLD_SWAB 0

////////////////////////////////////////////////////////////
// memory sizes and timing

`define DWNLD_BANK_AW 6
`define DWNLD_PROM_AW 6
// cycles from prog_we rising to the acknowledge pulse
`define DWNLD_ACK_LAT 3

`endif

/* hdl/prom_store.sv */
// PROM store
// byte-wide memory for the top part of the image, written while prom_we
// is high and read back combinationally
`timescale 1ns/1ps
`include "dwnld_settings.svh"

module prom_store (
    input  logic                      clk,
    input  logic                      prom_we,
    input  logic [`DWNLD_PROM_AW-1:0] prom_addr,
    input  logic [7:0]                prom_data,
    input  logic [`DWNLD_PROM_AW-1:0] prom_rd_addr,
    output logic [7:0]                prom_rd_data
);

    localparam int DEPTH = 2 ** `DWNLD_PROM_AW;

    logic [7:0] mem [0:DEPTH-1];

    ////////////////////////////////////////////////////////////
    // write port

    // prom_we is a level, so the same byte is written again on every
    // clock until the control logic drops it, which is harmless because
    // address and data hold still in the meantime
    always_ff @(posedge clk) begin
        if (prom_we) begin
            mem[prom_addr] <= prom_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // read-back port

    // asynchronous read, like a small LUT-based PROM
    assign prom_rd_data = mem[prom_rd_addr];

endmodule

/* hdl/rom_loader_top.sv */
// ROM download subsystem
// turns the loader byte stream into SDRAM program writes and PROM writes
// and keeps both behavioral stores for read-back of the loaded image
`timescale 1ns/1ps
`include "dwnld_settings.svh"

module rom_loader_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      downloading,
    input  logic                      ioctl_wr,
    input  dwnld_pkg::ioctl_beat_t    beat,
    input  logic [1:0]                rd_ba,
    input  logic [`DWNLD_BANK_AW-1:0] rd_addr,
    input  logic [`DWNLD_PROM_AW-1:0] prom_rd_addr,
    output logic                      prog_we,
    output logic                      prom_we,
    output logic                      sdram_ack,
    output logic [15:0]               rd_data,
    output logic [7:0]                prom_rd_data
);

    dwnld_pkg::region_t        region;
    dwnld_pkg::prog_req_t      req;
    logic [`DWNLD_PROM_AW-1:0] prom_addr;
    logic [7:0]                prom_data;

    ////////////////////////////////////////////////////////////
    // address decode and control

    dwnld_region_decode u_region_decode (
        .beat   (beat),
        .region (region)
    );

    dwnld_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .beat        (beat),
        .region      (region),
        .sdram_ack   (sdram_ack),
        .req         (req),
        .prog_we     (prog_we),
        .prom_addr   (prom_addr),
        .prom_data   (prom_data),
        .prom_we     (prom_we)
    );

    ////////////////////////////////////////////////////////////
    // memories

    sdram_prog_store u_sdram_prog_store (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .prog_we   (prog_we),
        .sdram_ack (sdram_ack),
        .rd_ba     (rd_ba),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    prom_store u_prom_store (
        .clk          (clk),
        .prom_we      (prom_we),
        .prom_addr    (prom_addr),
        .prom_data    (prom_data),
        .prom_rd_addr (prom_rd_addr),
        .prom_rd_data (prom_rd_data)
    );

endmodule

/* hdl/sdram_prog_store.sv */
// SDRAM programming port model
// four banks of 16-bit words written through an active-low byte mask,
// acknowledged a fixed number of cycles after prog_we rises
// a combinational read-back port exposes the loaded image
`timescale 1ns/1ps
`include "dwnld_settings.svh"

module sdram_prog_store (
    input  logic                      clk,
    input  logic                      reset,
    input  dwnld_pkg::prog_req_t      req,
    input  logic                      prog_we,
    output logic                      sdram_ack,
    input  logic [1:0]                rd_ba,
    input  logic [`DWNLD_BANK_AW-1:0] rd_addr,
    output logic [15:0]               rd_data
);

    localparam int AW    = `DWNLD_BANK_AW;
    localparam int LAT   = `DWNLD_ACK_LAT;
    localparam int CNT_W = $clog2(LAT + 1);
    localparam int DEPTH = 4 * (2 ** AW);

    // bank number sits above the word address
    logic [15:0]      mem [0:DEPTH-1];
    logic [CNT_W-1:0] lat_cnt;
    // the cycle in which the write lands and the acknowledge is raised
    logic             wr_fire;
    logic [AW+1:0]    wr_index;

    assign wr_fire  = prog_we && !sdram_ack && (lat_cnt == CNT_W'(LAT - 1));
    assign wr_index = {req.ba, req.addr[AW-1:0]};

    ////////////////////////////////////////////////////////////
    // acknowledge timing

    // the count restarts after every acknowledge, so a prog_we that stays
    // high for a back-to-back request gets a full latency again
    always_ff @(posedge clk) begin
        if (reset) begin
            lat_cnt   <= '0;
            sdram_ack <= 1'b0;
        end else begin
            sdram_ack <= wr_fire;
            if (!prog_we || sdram_ack || wr_fire) begin
                lat_cnt <= '0;
            end else begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // storage

    // lanes with their mask bit at 0 are written
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (!req.mask[1]) begin
                mem[wr_index][15:8] <= req.data[15:8];
            end
            if (!req.mask[0]) begin
                mem[wr_index][7:0] <= req.data[7:0];
            end
        end
    end

    // read-back for inspection of the image
    assign rd_data = mem[{rd_ba, rd_addr}];

    ////////////////////////////////////////////////////////////
    // request sanity

    // each loader byte belongs to one lane, so a request touching both
    // lanes means the control logic built the mask wrong
    a_single_lane: assert property (
        @(posedge clk) disable iff (reset)
        wr_fire |-> (req.mask != 2'b00)
    ) else $error("SDRAM write with both byte lanes enabled");

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the ROM download testbench with Verilator and run it
# the exit status of the simulation is the result of the run
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module tb_rom_loader \
    -o tb_rom_loader

./obj_dir/tb_rom_loader

/* sim.f */
+incdir+hdl
hdl/dwnld_pkg.sv
hdl/dwnld_region_decode.sv
hdl/dwnld_ctrl.sv
hdl/sdram_prog_store.sv
hdl/prom_store.sv
hdl/rom_loader_top.sv
tb/tb_rom_loader.sv

/* tb/tb_rom_loader.sv */
// ROM download testbench
// streams a random image through the loader port, checks the write enables
// and the acknowledge beat by beat, then reads back both stores
`timescale 1ns/1ps
`include "dwnld_settings.svh"

module tb_rom_loader;

    localparam int BAW             = `DWNLD_BANK_AW;
    localparam int PAW             = `DWNLD_PROM_AW;
    localparam int HEADER_LEN      = `DWNLD_HEADER_LEN;
    localparam int PROM_START      = `DWNLD_PROM_START;
    localparam int PROM_BYTES      = 16;
    localparam int IMAGE_LEN       = HEADER_LEN + PROM_START + PROM_BYTES;
    localparam int ACK_LAT         = `DWNLD_ACK_LAT;
    localparam int BANK_WORDS      = 2 ** BAW;
    localparam int WATCHDOG_CYCLES = IMAGE_LEN * 10 + 1000;
    localparam int SEED            = 79358;

    localparam logic [1:0] KIND_NONE  = 2'd0;
    localparam logic [1:0] KIND_SDRAM = 2'd1;
    localparam logic [1:0] KIND_PROM  = 2'd2;

    // where one image byte is expected to end up
    typedef struct packed {
        logic [1:0]     kind;
        logic [1:0]     bank;
        logic [BAW-1:0] word;
        // 1 is the upper lane, data[15:8]
        logic           lane;
        logic [PAW-1:0] prom_addr;
    } dest_t;

    logic                   clk;
    logic                   reset;
    logic                   downloading;
    logic                   ioctl_wr;
    dwnld_pkg::ioctl_beat_t beat;
    logic [1:0]             rd_ba;
    logic [BAW-1:0]         rd_addr;
    logic [PAW-1:0]         prom_rd_addr;
    logic                   prog_we;
    logic                   prom_we;
    logic                   sdram_ack;
    logic [15:0]            rd_data;
    logic [7:0]             prom_rd_data;

    logic [7:0] image [0:IMAGE_LEN-1];
    int         ack_count;
    int         sdram_beats;

    rom_loader_top u_rom_loader_top (
        .clk          (clk),
        .reset        (reset),
        .downloading  (downloading),
        .ioctl_wr     (ioctl_wr),
        .beat         (beat),
        .rd_ba        (rd_ba),
        .rd_addr      (rd_addr),
        .prom_rd_addr (prom_rd_addr),
        .prog_we      (prog_we),
        .prom_we      (prom_we),
        .sdram_ack    (sdram_ack),
        .rd_data      (rd_data),
        .prom_rd_data (prom_rd_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // every cycle with the acknowledge high counts once, sampled mid-cycle
    always @(negedge clk) begin
        if (sdram_ack) begin
            ack_count++;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model of the image layout

    // header bytes go nowhere, the top 16 bytes go to the PROM and the
    // rest is split over four banks of two bytes per word
    function automatic dest_t image_dest(input int idx);
        dest_t d;
        int    part;
        int    rel;
        d    = '0;
        part = idx - HEADER_LEN;
        rel  = 0;
        if (idx < HEADER_LEN) begin
            d.kind = KIND_NONE;
        end else if (part >= PROM_START) begin
            d.kind      = KIND_PROM;
            d.prom_addr = PAW'(part - PROM_START);
        end else begin
            d.kind = KIND_SDRAM;
            if (part >= `DWNLD_BA3_START) begin
                d.bank = 2'd3;
                rel    = part - `DWNLD_BA3_START;
            end else if (part >= `DWNLD_BA2_START) begin
                d.bank = 2'd2;
                rel    = part - `DWNLD_BA2_START;
            end else if (part >= `DWNLD_BA1_START) begin
                d.bank = 2'd1;
                rel    = part - `DWNLD_BA1_START;
            end else begin
                d.bank = 2'd0;
                rel    = part;
            end
            d.word = BAW'(rel / 2);
            d.lane = 1'(rel) ^ 1'(`DWNLD_SWAB);
        end
        return d;
    endfunction

    // lanes never reached by the image stay 0 here, so they show up as a mismatch
    function automatic logic [15:0] expected_word(input int ba, input int w);
        logic [15:0] word;
        dest_t       d;
        word = '0;
        for (int i = 0; i < IMAGE_LEN; i++) begin
            d = image_dest(i);
            if (d.kind == KIND_SDRAM && int'(d.bank) == ba && int'(d.word) == w) begin
                if (d.lane) begin
                    word[15:8] = image[i];
                end else begin
                    word[7:0] = image[i];
                end
            end
        end
        return word;
    endfunction

    function automatic logic [7:0] expected_prom(input int a);
        logic [7:0] value;
        dest_t      d;
        value = '0;
        for (int i = 0; i < IMAGE_LEN; i++) begin
            d = image_dest(i);
            if (d.kind == KIND_PROM && int'(d.prom_addr) == a) begin
                value = image[i];
            end
        end
        return value;
    endfunction

    ////////////////////////////////////////////////////////////
    // checking helpers

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopping at the first failed check");
    endtask

    // one strobe followed by idle cycles, entered and left 2 ns after a rising edge
    // the enables are checked mid-cycle against the destination of the byte
    task automatic send_beat(input int idx, input logic [7:0] data, input int idle);
        dest_t      d;
        logic [1:0] kind;
        int         n;
        d              = image_dest(idx);
        kind           = downloading ? d.kind : KIND_NONE;
        beat.addr      = 25'(idx);
        beat.data      = data;
        ioctl_wr       = 1'b1;
        @(posedge clk);
        #2;
        ioctl_wr = 1'b0;
        @(negedge clk);
        n = 1;
        assert (prog_we == (kind == KIND_SDRAM))
            else report_failure($sformatf("prog_we is %0b after beat %0d", prog_we, idx));
        assert (prom_we == (kind == KIND_PROM))
            else report_failure($sformatf("prom_we is %0b after beat %0d", prom_we, idx));
        if (kind == KIND_SDRAM) begin
            sdram_beats++;
            // prog_we has to hold until the memory answers
            while (!sdram_ack && n <= ACK_LAT + 4) begin
                assert (prog_we)
                    else report_failure($sformatf("prog_we fell early on beat %0d", idx));
                @(negedge clk);
                n++;
            end
            assert (sdram_ack)
                else report_failure($sformatf("no sdram_ack for beat %0d", idx));
            assert (n == ACK_LAT + 1)
                else report_failure($sformatf("ack latency %0d on beat %0d", n - 1, idx));
            @(negedge clk);
            n++;
            assert (!prog_we && !sdram_ack)
                else report_failure($sformatf("prog_we or ack still high, beat %0d", idx));
        end
        // a PROM byte keeps prom_we high, nothing else may move
        while (n < idle) begin
            @(negedge clk);
            n++;
            assert (!prog_we && !sdram_ack && prom_we == (kind == KIND_PROM))
                else report_failure($sformatf("enables wrong while idle after beat %0d", idx));
        end
        @(posedge clk);
        #2;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        void'($urandom(SEED));
        reset        = 1'b1;
        downloading  = 1'b0;
        ioctl_wr     = 1'b0;
        beat         = '0;
        rd_ba        = '0;
        rd_addr      = '0;
        prom_rd_addr = '0;
        ack_count    = 0;
        sdram_beats  = 0;
        for (int i = 0; i < IMAGE_LEN; i++) begin
            image[i] = 8'($urandom);
        end

        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (!prog_we && !prom_we && !sdram_ack)
            else report_failure("enables not low after reset");
        @(posedge clk);
        #2;
        downloading = 1'b1;

        // whole image, one byte per address in order
        for (int i = 0; i < IMAGE_LEN; i++) begin
            send_beat(i, image[i], ACK_LAT + 2 + int'($urandom % 4));
            if (i == HEADER_LEN - 1) begin
                assert (ack_count == 0)
                    else report_failure($sformatf("%0d acks during the header", ack_count));
            end
        end
        assert (ack_count == sdram_beats)
            else report_failure($sformatf("%0d acks for %0d SDRAM beats",
                                          ack_count, sdram_beats));

        // the image ends on a PROM byte, so prom_we is still up here
        assert (prom_we) else report_failure("prom_we low before the end of the download");
        downloading = 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (!prom_we && !prog_we) else report_failure("enables high after the download");
        @(posedge clk);
        #2;

        // late strobes with inverted data must leave both stores alone
        send_beat(HEADER_LEN, ~image[HEADER_LEN], ACK_LAT + 2);
        send_beat(IMAGE_LEN - 1, ~image[IMAGE_LEN - 1], ACK_LAT + 2);
        assert (ack_count == sdram_beats) else report_failure("ack after the download ended");

        for (int ba = 0; ba < 4; ba++) begin
            for (int w = 0; w < BANK_WORDS; w++) begin
                rd_ba   = 2'(ba);
                rd_addr = BAW'(w);
                @(negedge clk);
                assert (rd_data === expected_word(ba, w))
                    else report_failure($sformatf("bank %0d word %0d read %h expected %h",
                                                  ba, w, rd_data, expected_word(ba, w)));
                @(posedge clk);
                #2;
            end
        end

        for (int a = 0; a < PROM_BYTES; a++) begin
            prom_rd_addr = PAW'(a);
            @(negedge clk);
            assert (prom_rd_data === expected_prom(a))
                else report_failure($sformatf("PROM %0d read %h expected %h",
                                              a, prom_rd_data, expected_prom(a)));
            @(posedge clk);
            #2;
        end

        $display("Test OK");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // watchdog

    // about ten cycles per image byte covers the widest strobe spacing
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
